/* design/axi_lite_pkg.sv */
package axi_lite_pkg;

  // word address in data-width words rather than bytes
  localparam int axi_addr_width = 20;

  localparam int axi_data_width = 16;

  // strobe lanes carried on the port but not acted on
  localparam int axi_strb_width = axi_data_width / 8;

  // AXI-Lite response codes
  typedef enum logic [1:0] {
    axi_resp_okay   = 2'b00,
    axi_resp_exokay = 2'b01,
    axi_resp_slverr = 2'b10,
    axi_resp_decerr = 2'b11
  } axi_resp_e;

endpackage

/* design/sram_pkg.sv */
package sram_pkg;

  // pin buses match the AXI side one to one
  localparam int sram_addr_width = axi_lite_pkg::axi_addr_width;
  localparam int sram_data_width = axi_lite_pkg::axi_data_width;

  // cycles the strobes stay active per access
  localparam int sram_access_cycles = 2;

  // width of the access counter in the pin controller
  localparam int sram_cnt_width = $clog2(sram_access_cycles + 1);

  typedef enum logic [1:0] {
    st_idle,
    st_write,
    st_read,
    st_done
  } sram_state_e;

endpackage

/* design/axi_sram_controller.sv */
`timescale 1ns/1ns

// wstrb is ignored because the board ties both byte lanes on
module axi_sram_controller
  import axi_lite_pkg::*;
(
  input  logic                      axi_clk,
  input  logic                      axi_resetn,

  // write address channel
  input  logic [axi_addr_width-1:0] axi_awaddr,
  input  logic                      axi_awvalid,
  output logic                      axi_awready,

  // write data channel
  input  logic [axi_data_width-1:0] axi_wdata,
  input  logic [axi_strb_width-1:0] axi_wstrb,
  input  logic                      axi_wvalid,
  output logic                      axi_wready,

  // write response channel
  output logic [1:0]                axi_bresp,
  output logic                      axi_bvalid,
  input  logic                      axi_bready,

  // read address channel
  input  logic [axi_addr_width-1:0] axi_araddr,
  input  logic                      axi_arvalid,
  output logic                      axi_arready,

  // read data channel
  output logic [axi_data_width-1:0] axi_rdata,
  output logic [1:0]                axi_rresp,
  output logic                      axi_rvalid,
  input  logic                      axi_rready,

  // toward the pin controller
  output logic                      sram_req,
  output logic                      sram_write_enable,
  output logic [axi_addr_width-1:0] sram_addr_req,
  output logic [axi_data_width-1:0] sram_write_data,
  input  logic                      sram_ready,
  input  logic                      sram_write_done,
  input  logic [axi_data_width-1:0] sram_read_data,
  input  logic                      sram_read_data_valid
);

  typedef enum logic [2:0] {
    fe_idle,
    fe_write,
    fe_write_resp,
    fe_read,
    fe_read_resp
  } fe_state_e;

  fe_state_e state;
  fe_state_e state_next;

  // set when writes win the next tie and cleared by reset so reads go first
  logic pri_write;

  logic want_write;
  logic want_read;
  logic issue_write;
  logic issue_read;

  logic bvalid_q;
  logic rvalid_q;

  // arbitration only from idle with the pin controller free
  always_comb begin
    want_write  = axi_awvalid && axi_wvalid;
    want_read   = axi_arvalid;
    issue_write = 1'b0;
    issue_read  = 1'b0;
    if (state == fe_idle && sram_ready) begin
      if (want_write && (!want_read || pri_write)) begin
        issue_write = 1'b1;
      end else if (want_read) begin
        issue_read = 1'b1;
      end
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      fe_idle: begin
        if (issue_write) begin
          state_next = fe_write;
        end else if (issue_read) begin
          state_next = fe_read;
        end
      end
      fe_write: begin
        if (sram_write_done) begin
          state_next = fe_write_resp;
        end
      end
      fe_write_resp: begin
        if (bvalid_q && axi_bready) begin
          state_next = fe_idle;
        end
      end
      fe_read: begin
        if (sram_read_data_valid) begin
          state_next = fe_read_resp;
        end
      end
      fe_read_resp: begin
        if (rvalid_q && axi_rready) begin
          state_next = fe_idle;
        end
      end
      default: state_next = fe_idle;
    endcase
  end

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      state     <= fe_idle;
      pri_write <= 1'b0;
    end else begin
      state <= state_next;
      // the side that just lost gets the next tie
      if (sram_req) begin
        pri_write <= !sram_write_enable;
      end
    end
  end

  // hold the one-cycle done pulses until the master takes the response
  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (sram_write_done) begin
        bvalid_q <= 1'b1;
      end else if (bvalid_q && axi_bready) begin
        bvalid_q <= 1'b0;
      end
      if (sram_read_data_valid) begin
        rvalid_q <= 1'b1;
      end else if (rvalid_q && axi_rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // handshakes land in the same cycle as the request
  assign axi_awready = issue_write;
  assign axi_wready  = issue_write;
  assign axi_arready = issue_read;

  assign axi_bvalid = bvalid_q;
  assign axi_bresp  = axi_resp_okay;
  assign axi_rvalid = rvalid_q;
  assign axi_rresp  = axi_resp_okay;

  // pin controller keeps read data until the next read and none starts while rvalid is up
  assign axi_rdata = sram_read_data;

  assign sram_req          = issue_write || issue_read;
  assign sram_write_enable = issue_write;
  assign sram_addr_req     = issue_write ? axi_awaddr : axi_araddr;
  assign sram_write_data   = axi_wdata;

endmodule

/* design/sram_controller.sv */
`timescale 1ns/1ns

module sram_controller
  import axi_lite_pkg::*, sram_pkg::*;
(
  input  logic                       axi_clk,
  input  logic                       axi_resetn,

  // request side
  input  logic                       req,
  input  logic                       write_enable,
  input  logic [axi_addr_width-1:0]  addr,
  input  logic [axi_data_width-1:0]  write_data,
  output logic                       ready,
  output logic                       write_done,
  output logic [axi_data_width-1:0]  read_data,
  output logic                       read_data_valid,

  // SRAM pins
  output logic [sram_addr_width-1:0] sram_addr,
  inout  wire  [sram_data_width-1:0] sram_dq,
  output logic                       sram_we_n,
  output logic                       sram_oe_n,
  output logic                       sram_ce_n
);

  sram_state_e state;

  logic [sram_cnt_width-1:0]  cnt;
  logic                       cnt_last;
  logic                       take;
  logic [sram_addr_width-1:0] addr_q;
  logic [sram_data_width-1:0] data_q;

  assign take     = req && ready;
  assign cnt_last = cnt == sram_cnt_width'(sram_access_cycles - 1);

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      state           <= st_idle;
      ready           <= 1'b0;
      cnt             <= '0;
      write_done      <= 1'b0;
      read_data_valid <= 1'b0;
    end else begin
      write_done      <= 1'b0;
      read_data_valid <= 1'b0;
      case (state)
        st_idle: begin
          ready <= 1'b1;
          cnt   <= '0;
          if (take) begin
            ready <= 1'b0;
            if (write_enable) begin
              state <= st_write;
            end else begin
              state <= st_read;
            end
          end
        end
        st_write: begin
          if (cnt_last) begin
            state      <= st_done;
            write_done <= 1'b1;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        st_read: begin
          if (cnt_last) begin
            state           <= st_done;
            read_data_valid <= 1'b1;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        st_done: begin
          state <= st_idle;
          ready <= 1'b1;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // address and write data held for the whole access
  always_ff @(posedge axi_clk) begin
    if (take) begin
      addr_q <= addr;
      data_q <= write_data;
    end
    // sample on the last cycle with oe still low
    if (state == st_read && cnt_last) begin
      read_data <= sram_dq;
    end
  end

  assign sram_addr = addr_q;
  assign sram_ce_n = !(state == st_write || state == st_read);
  assign sram_we_n = state != st_write;
  assign sram_oe_n = state != st_read;

  // bus released outside of writes
  assign sram_dq = (state == st_write) ? data_q : {sram_data_width{1'bz}};

endmodule

/* design/axi_sram_top.sv */
`timescale 1ns/1ns

module axi_sram_top
  import axi_lite_pkg::*, sram_pkg::*;
(
  input  logic                       axi_clk,
  input  logic                       axi_resetn,
  input  logic [axi_addr_width-1:0]  axi_awaddr,
  input  logic                       axi_awvalid,
  output logic                       axi_awready,
  input  logic [axi_data_width-1:0]  axi_wdata,
  input  logic [axi_strb_width-1:0]  axi_wstrb,
  input  logic                       axi_wvalid,
  output logic                       axi_wready,
  output logic [1:0]                 axi_bresp,
  output logic                       axi_bvalid,
  input  logic                       axi_bready,
  input  logic [axi_addr_width-1:0]  axi_araddr,
  input  logic                       axi_arvalid,
  output logic                       axi_arready,
  output logic [axi_data_width-1:0]  axi_rdata,
  output logic [1:0]                 axi_rresp,
  output logic                       axi_rvalid,
  input  logic                       axi_rready,
  output logic [sram_addr_width-1:0] sram_addr,
  inout  wire  [sram_data_width-1:0] sram_dq,
  output logic                       sram_we_n,
  output logic                       sram_oe_n,
  output logic                       sram_ce_n
);

  // front end to pin controller
  logic                      req;
  logic                      write_enable;
  logic [axi_addr_width-1:0] addr;
  logic [axi_data_width-1:0] write_data;
  logic                      ready;
  logic                      write_done;
  logic [axi_data_width-1:0] read_data;
  logic                      read_data_valid;

  axi_sram_controller i_axi_sram_controller (
    .axi_clk              (axi_clk),
    .axi_resetn           (axi_resetn),
    .axi_awaddr           (axi_awaddr),
    .axi_awvalid          (axi_awvalid),
    .axi_awready          (axi_awready),
    .axi_wdata            (axi_wdata),
    .axi_wstrb            (axi_wstrb),
    .axi_wvalid           (axi_wvalid),
    .axi_wready           (axi_wready),
    .axi_bresp            (axi_bresp),
    .axi_bvalid           (axi_bvalid),
    .axi_bready           (axi_bready),
    .axi_araddr           (axi_araddr),
    .axi_arvalid          (axi_arvalid),
    .axi_arready          (axi_arready),
    .axi_rdata            (axi_rdata),
    .axi_rresp            (axi_rresp),
    .axi_rvalid           (axi_rvalid),
    .axi_rready           (axi_rready),
    .sram_req             (req),
    .sram_write_enable    (write_enable),
    .sram_addr_req        (addr),
    .sram_write_data      (write_data),
    .sram_ready           (ready),
    .sram_write_done      (write_done),
    .sram_read_data       (read_data),
    .sram_read_data_valid (read_data_valid)
  );

  sram_controller i_sram_controller (
    .axi_clk         (axi_clk),
    .axi_resetn      (axi_resetn),
    .req             (req),
    .write_enable    (write_enable),
    .addr            (addr),
    .write_data      (write_data),
    .ready           (ready),
    .write_done      (write_done),
    .read_data       (read_data),
    .read_data_valid (read_data_valid),
    .sram_addr       (sram_addr),
    .sram_dq         (sram_dq),
    .sram_we_n       (sram_we_n),
    .sram_oe_n       (sram_oe_n),
    .sram_ce_n       (sram_ce_n)
  );

endmodule

/* dv/sram_model.sv */
`timescale 1ns/1ns

// asynchronous SRAM that takes a write shortly after we_n falls
module sram_model
  import sram_pkg::*;
(
  input  logic [sram_addr_width-1:0] addr,
  inout  wire  [sram_data_width-1:0] dq,
  input  logic                       we_n,
  input  logic                       oe_n,
  input  logic                       ce_n
);

  logic [sram_data_width-1:0] mem [0:(1 << sram_addr_width)-1];

  // give the data bus time to settle before the write lands
  always @(negedge we_n) begin
    #1;
    if (!ce_n && !we_n) begin
      mem[addr] = dq;
    end
  end

  // drive only while selected for a read
  assign dq = (!ce_n && !oe_n && we_n) ? mem[addr] : {sram_data_width{1'bz}};

endmodule

/* dv/axi_sram_tb.sv */
`timescale 1ns/1ns

module axi_sram_tb
  import axi_lite_pkg::*, sram_pkg::*;
;

  // worst case per transaction is the access plus handshakes plus stall, with margin on top
  localparam int timeout_cycles = 300 * (sram_access_cycles + 6) + 1600;
  localparam logic [15:0] win_base = 16'h5a5a;

  logic                      axi_clk;
  logic                      axi_resetn;
  logic [axi_addr_width-1:0] axi_awaddr;
  logic                      axi_awvalid;
  logic                      axi_awready;
  logic [axi_data_width-1:0] axi_wdata;
  logic [axi_strb_width-1:0] axi_wstrb;
  logic                      axi_wvalid;
  logic                      axi_wready;
  logic [1:0]                axi_bresp;
  logic                      axi_bvalid;
  logic                      axi_bready;
  logic [axi_addr_width-1:0] axi_araddr;
  logic                      axi_arvalid;
  logic                      axi_arready;
  logic [axi_data_width-1:0] axi_rdata;
  logic [1:0]                axi_rresp;
  logic                      axi_rvalid;
  logic                      axi_rready;
  logic [sram_addr_width-1:0] sram_addr;
  wire  [sram_data_width-1:0] sram_dq;
  logic                       sram_we_n;
  logic                       sram_oe_n;
  logic                       sram_ce_n;

  int          errors = 0;
  int          tests;
  int          cycle = 0;
  logic [31:0] rng;

  // reference memory over the 16-word window
  logic [axi_data_width-1:0] ref_mem [0:15];
  logic [axi_data_width-1:0] exp_rdata;
  logic [axi_data_width-1:0] rdata_d;
  logic [1:0] rresp_d;
  logic [1:0] bresp_d;
  logic rvalid_d;
  logic rready_d;
  logic bvalid_d;
  logic bready_d;
  logic rst_d;
  logic last_write;
  logic [3:0] ar_pipe;
  logic [3:0] aw_pipe;

  logic aw_hs;
  logic w_hs;
  logic ar_hs;
  logic r_hs;
  logic b_hs;
  logic both_pending;

  assign aw_hs = axi_awvalid && axi_awready;
  assign w_hs  = axi_wvalid && axi_wready;
  assign ar_hs = axi_arvalid && axi_arready;
  assign r_hs  = axi_rvalid && axi_rready;
  assign b_hs  = axi_bvalid && axi_bready;
  assign both_pending = axi_arvalid && axi_awvalid && axi_wvalid;

  axi_sram_top i_axi_sram_top (.*);

  sram_model i_sram_model (
    .addr (sram_addr),
    .dq   (sram_dq),
    .we_n (sram_we_n),
    .oe_n (sram_oe_n),
    .ce_n (sram_ce_n)
  );

  always #4 axi_clk = !axi_clk;

  always @(posedge axi_clk) begin
    cycle <= cycle + 1;
    if (cycle >= timeout_cycles) begin
      $display("timeout, the run did not finish within %0d cycles", timeout_cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // history of the bus for the assertions
  always @(posedge axi_clk) begin
    rst_d    <= !axi_resetn;
    rdata_d  <= axi_rdata;
    rresp_d  <= axi_rresp;
    bresp_d  <= axi_bresp;
    rvalid_d <= axi_rvalid;
    rready_d <= axi_rready;
    bvalid_d <= axi_bvalid;
    bready_d <= axi_bready;
    if (!axi_resetn) begin
      last_write <= 1'b1;
      ar_pipe    <= '0;
      aw_pipe    <= '0;
    end else begin
      ar_pipe <= {ar_pipe[2:0], ar_hs};
      aw_pipe <= {aw_pipe[2:0], aw_hs};
      if (aw_hs || ar_hs) begin
        last_write <= aw_hs;
      end
      if (aw_hs) begin
        ref_mem[axi_awaddr[3:0]] <= axi_wdata;
      end
      if (ar_hs) begin
        exp_rdata <= ref_mem[axi_araddr[3:0]];
      end
    end
  end

  task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] got);
    errors++;
    $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
  endtask

  task automatic rule_error(input string what);
    errors++;
    $display("%0t %s", $time, what);
  endtask

  a_reset: assert property (@(posedge axi_clk) (cycle > 1 && (!axi_resetn || rst_d)) |->
    (!axi_awready && !axi_wready && !axi_arready && !axi_bvalid && !axi_rvalid &&
     sram_we_n && sram_oe_n && sram_ce_n))
    else rule_error("outputs not idle during or right after reset");

  a_rdata: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    r_hs |-> axi_rdata == exp_rdata)
    else value_error("axi_rdata", 32'($sampled(exp_rdata)), 32'($sampled(axi_rdata)));

  a_rresp: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    r_hs |-> axi_rresp == axi_resp_okay)
    else value_error("axi_rresp", 32'(axi_resp_okay), 32'($sampled(axi_rresp)));

  a_bresp: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    b_hs |-> axi_bresp == axi_resp_okay)
    else value_error("axi_bresp", 32'(axi_resp_okay), 32'($sampled(axi_bresp)));

  a_aw_w: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    aw_hs == w_hs)
    else rule_error("aw and w handshakes did not happen in the same cycle");

  a_r_latency: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    (axi_rvalid && !rvalid_d) == ar_pipe[3])
    else rule_error("rvalid did not rise exactly 4 cycles after the ar handshake");

  a_b_latency: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    (axi_bvalid && !bvalid_d) == aw_pipe[3])
    else rule_error("bvalid did not rise exactly 4 cycles after the aw/w handshake");

  a_r_hold: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    (rvalid_d && !rready_d) |-> (axi_rvalid && axi_rdata == rdata_d && axi_rresp == rresp_d))
    else rule_error("read response changed or dropped before rready");

  a_b_hold: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    (bvalid_d && !bready_d) |-> (axi_bvalid && axi_bresp == bresp_d))
    else rule_error("write response changed or dropped before bready");

  a_blocked: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    (axi_bvalid || axi_rvalid) |-> !(aw_hs || w_hs || ar_hs))
    else rule_error("request accepted while a response was pending");

  a_fair: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    ((aw_hs || ar_hs) && both_pending) |-> aw_hs != last_write)
    else rule_error("arbitration did not alternate between read and write");

  a_strobes: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    (sram_we_n || sram_oe_n) && (!sram_ce_n || (sram_we_n && sram_oe_n)))
    else rule_error("SRAM strobes broke the bus rules");

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic apply_reset();
    axi_resetn <= 1'b0;
    repeat (8) @(posedge axi_clk);
    axi_resetn <= 1'b1;
    repeat (2) @(posedge axi_clk);
  endtask

  // called right after a rising edge, so the next request overlaps the last response
  task automatic write_word(input logic [3:0] idx, input logic [15:0] data,
                            input logic [axi_strb_width-1:0] strb, input int stall);
    axi_awaddr  <= {win_base, idx};
    axi_wdata   <= data;
    axi_wstrb   <= strb;
    axi_awvalid <= 1'b1;
    axi_wvalid  <= 1'b1;
    do @(negedge axi_clk); while (!axi_awready);
    @(posedge axi_clk);
    axi_awvalid <= 1'b0;
    axi_wvalid  <= 1'b0;
    do @(negedge axi_clk); while (!axi_bvalid);
    repeat (stall + 1) @(posedge axi_clk);
    axi_bready <= 1'b1;
    @(negedge axi_clk);
    @(posedge axi_clk);
    axi_bready <= 1'b0;
  endtask

  task automatic read_word(input logic [3:0] idx, input int stall);
    axi_araddr  <= {win_base, idx};
    axi_arvalid <= 1'b1;
    do @(negedge axi_clk); while (!axi_arready);
    @(posedge axi_clk);
    axi_arvalid <= 1'b0;
    do @(negedge axi_clk); while (!axi_rvalid);
    repeat (stall + 1) @(posedge axi_clk);
    axi_rready <= 1'b1;
    @(negedge axi_clk);
    @(posedge axi_clk);
    axi_rready <= 1'b0;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s finished, %0d errors so far", tests, name, errors);
  endtask

  initial begin
    axi_clk = 1'b0;
    axi_resetn = 1'b0;
    axi_awaddr = '0;
    axi_awvalid = 1'b0;
    axi_wdata = '0;
    axi_wstrb = '0;
    axi_wvalid = 1'b0;
    axi_bready = 1'b0;
    axi_araddr = '0;
    axi_arvalid = 1'b0;
    axi_rready = 1'b0;
    tests = 0;
    rng = 32'hdcd68d03;

    apply_reset();
    end_test("reset state");

    // fill the window and read each word straight back
    for (int i = 0; i < 16; i++) begin
      rng = xorshift(rng);
      write_word(4'(i), rng[15:0], axi_strb_width'(rng[17:16]), 0);
      read_word(4'(i), 0);
    end
    end_test("write then read back");

    for (int i = 0; i < 8; i++) begin
      rng = xorshift(rng);
      write_word(rng[3:0], rng[31:16], axi_strb_width'(rng[5:4]), 0);
      read_word(rng[3:0], 0);
    end
    end_test("fixed latency");

    for (int i = 0; i < 20; i++) begin
      rng = xorshift(rng);
      if (rng[8]) begin
        write_word(rng[3:0], rng[31:16], axi_strb_width'(rng[7:6]), int'(rng[5:4]));
      end else begin
        read_word(rng[3:0], int'(rng[5:4]));
      end
    end
    end_test("back-pressure");

    apply_reset();
    fork
      for (int i = 0; i < 10; i++) begin
        write_word(4'(i), 16'(i * 16'h1111), '1, 0);
      end
      for (int i = 0; i < 10; i++) begin
        read_word(4'(15 - i), 0);
      end
    join
    end_test("fairness");

    for (int i = 0; i < 200; i++) begin
      rng = xorshift(rng);
      if (rng[9]) begin
        write_word(rng[3:0], rng[31:16], axi_strb_width'(rng[7:6]), int'(rng[5:4]));
      end else begin
        read_word(rng[3:0], int'(rng[5:4]));
      end
    end
    end_test("random traffic");

    repeat (4) @(posedge axi_clk);
    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* axi_sram.f */
design/axi_lite_pkg.sv
design/sram_pkg.sv
design/axi_sram_controller.sv
design/sram_controller.sv
design/axi_sram_top.sv
dv/sram_model.sv
dv/axi_sram_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
    --top-module axi_sram_tb -f axi_sram.f -o axi_sram_sim; then
  echo "build failed"
  exit 1
fi

output=$(./obj_dir/axi_sram_sim)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Simulation PASSED"; then
  exit 0
fi
exit 1
